//--- compile.f
+incdir+bench
hdl/fp_add_pkg.sv
hdl/fp_unpack_align.sv
hdl/fp_mag_add.sv
hdl/fp_normalize.sv
hdl/fp_out_credit.sv
hdl/fp_add_top.sv
bench/fp_add_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module fp_add_tb -o fp_add_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/fp_add_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- bench/fp_add_model.svh
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// expected binary32 sum with truncation, flushed denormals and +inf for inf or nan
function automatic logic [31:0] fp_add_ref(input logic [31:0] a, input logic [31:0] b);
    int   ea;
    int   eb;
    int   sa;
    int   sb;
    int   e;
    int   big_sig;
    int   small_sig;
    int   diff;
    int   sum;
    logic sign;
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    if (ea == 255 || eb == 255) return 32'h7f80_0000;
    if (ea == 0 && eb == 0) return 32'h0;
    if (ea == 0) return b;
    if (eb == 0) return a;
    sa = int'({1'b1, a[22:0]});
    sb = int'({1'b1, b[22:0]});
    if ((ea > eb) || ((ea == eb) && (sa >= sb))) begin
        e         = ea;
        big_sig   = sa;
        small_sig = sb;
        diff      = ea - eb;
        sign      = a[31];
    end else begin
        e         = eb;
        big_sig   = sb;
        small_sig = sa;
        diff      = eb - ea;
        sign      = b[31];
    end
    small_sig = (diff >= 24) ? 0 : (small_sig >> diff);
    sum       = (a[31] == b[31]) ? big_sig + small_sig : big_sig - small_sig;
    if (sum == 0) return 32'h0;
    if (sum >= (1 << 24)) begin
        e = e + 1;
        if (e >= 255) return {sign, 8'hff, 23'h0};
        sum = sum >> 1;
    end
    while (sum < (1 << 23)) begin
        sum = sum << 1;
        e   = e - 1;
    end
    if (e <= 0) return 32'h0;
    return {sign, e[7:0], sum[22:0]};
endfunction

`endif

//--- bench/fp_add_tb.sv
module fp_add_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OUT_DEPTH    = 8;
    localparam int DOWN_CREDITS = 4;
    localparam int TIMEOUT      = 2000;

    logic                 i_clk    = 1'b0;
    logic                 i_rst_n  = 1'b0;
    logic                 i_valid  = 1'b0;
    fp_add_pkg::fp_word_t i_fp1    = '0;
    fp_add_pkg::fp_word_t i_fp2    = '0;
    logic                 i_credit = 1'b0;
    logic                 o_in_credit;
    logic                 o_valid;
    fp_add_pkg::fp_word_t o_fp;

    logic [31:0] exp_q[$];            // oldest expected result first
    logic [31:0] exp_head    = '0;
    logic        head_ok     = 1'b0;
    logic        hold_credit = 1'b0;
    logic        timed_out   = 1'b0;
    int          up_credits  = OUT_DEPTH;
    int          outstanding = 0;     // delivered but slot not yet returned
    int          results_seen = 0;
    int          errors      = 0;
    int          errors_at_start = 0;
    int          test_num    = 0;

    `include "fp_add_model.svh"

    fp_add_top #(
        .OUT_DEPTH    (OUT_DEPTH),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) fp_add_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_fp1       (i_fp1),
        .i_fp2       (i_fp2),
        .i_credit    (i_credit),
        .o_in_credit (o_in_credit),
        .o_valid     (o_valid),
        .o_fp        (o_fp)
    );

    always #50 i_clk = ~i_clk;

    // upstream credits, downstream slot returns and the expected queue
    always @(posedge i_clk) begin
        logic give;
        give = !hold_credit && (outstanding - int'(i_credit) > 0) && ($urandom_range(2) == 0);
        if (!i_rst_n) begin
            i_credit    <= 1'b0;
            up_credits  <= OUT_DEPTH;
            outstanding <= 0;
        end else begin
            i_credit     <= give;
            up_credits   <= up_credits - int'(i_valid) + int'(o_in_credit);
            outstanding  <= outstanding + int'(o_valid) - int'(i_credit);
            results_seen <= results_seen + int'(o_valid);
            if (o_valid && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
        end
    end

    always @(negedge i_clk) begin
        head_ok  = (exp_q.size() > 0);
        exp_head = head_ok ? exp_q[0] : '0;
    end

    result_expected: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> head_ok)
        else begin
            errors++;
            $display("a result came out with no operand pair waiting for it");
        end

    result_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && head_ok) |-> (o_fp == exp_head))
        else begin
            errors++;
            $display("[ERROR] o_fp expected %08h got %08h", $sampled(exp_head), $sampled(o_fp));
        end

    credit_per_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid == o_in_credit)
        else begin
            errors++;
            $display("o_in_credit did not pulse together with o_valid");
        end

    down_credit_limit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> (outstanding < DOWN_CREDITS))
        else begin
            errors++;
            $display("o_valid without a downstream credit left");
        end

    up_credit_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (up_credits >= 0) && (up_credits <= OUT_DEPTH))
        else begin
            errors++;
            $display("upstream credit count left its range");
        end

    // credits left after the spend and return of this edge
    function automatic int free_credits();
        return up_credits - int'(i_valid) + int'(o_in_credit);
    endfunction

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(posedge i_clk);
            while (free_credits() <= 0 && waited < TIMEOUT) begin
                i_valid <= 1'b0;
                waited++;
                @(posedge i_clk);
            end
            if (free_credits() <= 0) begin
                i_valid <= 1'b0;
                report_timeout("an upstream credit");
            end else begin
                i_valid <= 1'b1;
                i_fp1   <= a;
                i_fp2   <= b;
                exp_q.push_back(fp_add_ref(a, b));
            end
        end
    endtask

    task automatic idle_input(input int cycles);
        @(posedge i_clk);
        i_valid <= 1'b0;
        repeat (cycles - 1) @(posedge i_clk);
    endtask

    task automatic drain_results(input string name);
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_valid <= 1'b0;
        @(negedge i_clk);
        while ((exp_q.size() > 0 || outstanding > 0) && waited < TIMEOUT) begin
            waited++;
            @(negedge i_clk);
        end
        if (exp_q.size() > 0 || outstanding > 0) begin
            report_timeout({"all results of ", name});
        end
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        int          base;
        void'($urandom(3));
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        assert (!o_valid && !o_in_credit) else begin
            errors++;
            $display("o_valid or o_in_credit was high right after reset");
        end

        send_pair(32'h3fc0_0000, 32'h3fc0_0000);   // carry out
        send_pair(32'hc120_0000, 32'hc0a0_0000);
        send_pair(32'h3f80_0000, 32'h3300_0000);   // small part truncated away
        send_pair(32'h3f80_0000, 32'h33ff_ffff);
        drain_results("like-signed addition");

        send_pair(32'h3f80_0001, 32'hbf80_0000);   // long left shift
        send_pair(32'hc2c8_0000, 32'h42c7_fffe);
        send_pair(32'h4040_0000, 32'hc040_0000);   // exact cancellation
        drain_results("opposite-signed subtraction");

        send_pair(32'h7f80_0000, 32'h3f80_0000);
        send_pair(32'hbf80_0000, 32'h7fc0_0000);
        send_pair(32'hff80_0000, 32'h0000_0000);
        send_pair(32'h0000_0000, 32'hc049_0fdb);
        send_pair(32'h8000_0000, 32'h3f80_0000);
        send_pair(32'h0000_0001, 32'h4000_0000);   // denormal acts as zero
        drain_results("special operands");

        send_pair(32'h7f7f_ffff, 32'h7f7f_ffff);
        send_pair(32'hff7f_ffff, 32'hff7f_ffff);
        send_pair(32'h0080_0001, 32'h8080_0000);
        send_pair(32'h0100_0001, 32'h8100_0000);
        drain_results("range limits");

        // downstream keeps its slots, so only DOWN_CREDITS results may leave
        hold_credit <= 1'b1;
        base = results_seen;
        for (int i = 0; i < 12; i++) begin
            send_pair(32'h3f80_0000 + 32'(i), 32'h4000_0000 + 32'(i << 12));
            if (i == 7) begin
                idle_input(60);
            end
        end
        idle_input(40);
        assert (results_seen - base == DOWN_CREDITS) else begin
            errors++;
            $display("%0d results left while downstream held its credits",
                     results_seen - base);
        end
        hold_credit <= 1'b0;
        drain_results("flow control");

        for (int i = 0; i < 500; i++) begin
            ra = $urandom();
            rb = $urandom();
            if ($urandom_range(1) == 1) begin
                rb[30:23] = ra[30:23] + 8'($urandom_range(4)) - 8'd2;   // close exponents
            end
            send_pair(ra, rb);
        end
        drain_results("random stream");

        $display("summary: %0d tests, %0d results checked, %0d errors, %0d still expected",
                 test_num, results_seen, errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- hdl/fp_add_top.sv
module fp_add_top #(
    parameter int OUT_DEPTH    = 8,
    parameter int DOWN_CREDITS = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  fp_add_pkg::fp_word_t i_fp1,
    input  fp_add_pkg::fp_word_t i_fp2,
    input  logic                 i_credit,
    output logic                 o_in_credit,
    output logic                 o_valid,
    output fp_add_pkg::fp_word_t o_fp
);
    // stage 1 to stage 2
    logic                 s1_valid;
    logic                 s1_big_sign;
    logic                 s1_small_sign;
    fp_add_pkg::exp_t     s1_exp;
    fp_add_pkg::sig_t     s1_big_sig;
    fp_add_pkg::sig_t     s1_small_sig;
    logic                 s1_force_inf;
    logic                 s1_pass_zero;

    // stage 2 to stage 3
    logic                 s2_valid;
    logic                 s2_sign;
    fp_add_pkg::exp_t     s2_exp;
    fp_add_pkg::sum_t     s2_sum;
    logic                 s2_force_inf;
    logic                 s2_is_zero;

    logic                 s3_valid;
    fp_add_pkg::fp_word_t s3_fp;

    fp_unpack_align fp_unpack_align_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_fp1        (i_fp1),
        .i_fp2        (i_fp2),
        .o_valid      (s1_valid),
        .o_big_sign   (s1_big_sign),
        .o_small_sign (s1_small_sign),
        .o_exp        (s1_exp),
        .o_big_sig    (s1_big_sig),
        .o_small_sig  (s1_small_sig),
        .o_force_inf  (s1_force_inf),
        .o_pass_zero  (s1_pass_zero)
    );

    fp_mag_add fp_mag_add_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (s1_valid),
        .i_big_sign   (s1_big_sign),
        .i_small_sign (s1_small_sign),
        .i_exp        (s1_exp),
        .i_big_sig    (s1_big_sig),
        .i_small_sig  (s1_small_sig),
        .i_force_inf  (s1_force_inf),
        .i_pass_zero  (s1_pass_zero),
        .o_valid      (s2_valid),
        .o_sign       (s2_sign),
        .o_exp        (s2_exp),
        .o_sum        (s2_sum),
        .o_force_inf  (s2_force_inf),
        .o_is_zero    (s2_is_zero)
    );

    fp_normalize fp_normalize_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (s2_valid),
        .i_sign      (s2_sign),
        .i_exp       (s2_exp),
        .i_sum       (s2_sum),
        .i_force_inf (s2_force_inf),
        .i_is_zero   (s2_is_zero),
        .o_valid     (s3_valid),
        .o_fp        (s3_fp)
    );

    fp_out_credit #(
        .OUT_DEPTH    (OUT_DEPTH),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) fp_out_credit_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_valid  (s3_valid),
        .i_wr_data   (s3_fp),
        .i_credit    (i_credit),
        .o_valid     (o_valid),
        .o_fp        (o_fp),
        .o_in_credit (o_in_credit)
    );

endmodule

//--- hdl/fp_out_credit.sv
module fp_out_credit #(
    parameter int OUT_DEPTH    = 8,
    parameter int DOWN_CREDITS = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_wr_valid,
    input  fp_add_pkg::fp_word_t i_wr_data,
    input  logic                 i_credit,
    output logic                 o_valid,
    output fp_add_pkg::fp_word_t o_fp,
    output logic                 o_in_credit
);
    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CRD_W = $clog2(DOWN_CREDITS + 1);

    fp_add_pkg::fp_word_t mem [OUT_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] down_credit;
    logic             pop;

    // one result leaves per cycle while data and downstream space exist
    assign pop = (count != '0) && (down_credit != '0);

    assign o_valid     = pop;
    assign o_fp        = mem[rd_ptr];
    assign o_in_credit = pop;                   // freed slot goes back upstream

    always_ff @(posedge i_clk) begin
        if (i_wr_valid) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
        end else begin
            case ({i_wr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            down_credit <= CRD_W'(DOWN_CREDITS);
        end else begin
            case ({i_credit, pop})
                2'b10:   down_credit <= down_credit + 1'b1;
                2'b01:   down_credit <= down_credit - 1'b1;
                default: down_credit <= down_credit;   // spent and returned together
            endcase
        end
    end

endmodule

//--- hdl/fp_normalize.sv
module fp_normalize (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  logic                 i_sign,
    input  fp_add_pkg::exp_t     i_exp,
    input  fp_add_pkg::sum_t     i_sum,
    input  logic                 i_force_inf,
    input  logic                 i_is_zero,
    output logic                 o_valid,
    output fp_add_pkg::fp_word_t o_fp
);
    localparam int LZ_W = $bits(fp_add_pkg::lz_t);

    fp_add_pkg::lz_t              lz;
    fp_add_pkg::sig_t             norm_sig;
    logic [fp_add_pkg::EXP_W+1:0] exp_up;
    logic [fp_add_pkg::EXP_W+1:0] exp_dn;
    logic                         carry;
    logic                         res_sign;
    fp_add_pkg::exp_t             res_exp;
    logic [fp_add_pkg::MAN_W-1:0] res_man;

    assign carry = i_sum[fp_add_pkg::SIG_W];

    // highest set bit wins since it is visited last
    always_comb begin
        lz = fp_add_pkg::lz_t'(fp_add_pkg::SIG_W);
        for (int i = 0; i < fp_add_pkg::SIG_W; i++) begin
            if (i_sum[i]) begin
                lz = fp_add_pkg::lz_t'(fp_add_pkg::SIG_W - 1 - i);
            end
        end
    end

    assign norm_sig = i_sum[fp_add_pkg::SIG_W-1:0] << lz;

    assign exp_up = {2'b00, i_exp} + {{(fp_add_pkg::EXP_W+1){1'b0}}, 1'b1};
    assign exp_dn = {2'b00, i_exp} - {{(fp_add_pkg::EXP_W+2-LZ_W){1'b0}}, lz};

    always_comb begin
        res_sign = i_sign;
        res_exp  = i_exp;
        res_man  = norm_sig[fp_add_pkg::MAN_W-1:0];
        if (i_force_inf) begin
            res_sign = 1'b0;                          // inf or nan in gives +inf
            res_exp  = fp_add_pkg::EXP_MAX;
            res_man  = '0;
        end else if (i_is_zero) begin
            res_sign = 1'b0;
            res_exp  = '0;
            res_man  = '0;
        end else if (carry) begin
            if (exp_up >= {2'b00, fp_add_pkg::EXP_MAX}) begin
                res_exp = fp_add_pkg::EXP_MAX;        // signed infinity
                res_man = '0;
            end else begin
                res_exp = exp_up[fp_add_pkg::EXP_W-1:0];
                res_man = i_sum[fp_add_pkg::SIG_W-1:1];  // lsb truncated
            end
        end else if (exp_dn[fp_add_pkg::EXP_W+1] || (exp_dn == '0)) begin
            res_sign = 1'b0;                          // underflow gives +0
            res_exp  = '0;
            res_man  = '0;
        end else begin
            res_exp = exp_dn[fp_add_pkg::EXP_W-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_fp <= {res_sign, res_exp, res_man};
        end
    end

endmodule

//--- hdl/fp_mag_add.sv
module fp_mag_add (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_valid,
    input  logic             i_big_sign,
    input  logic             i_small_sign,
    input  fp_add_pkg::exp_t i_exp,
    input  fp_add_pkg::sig_t i_big_sig,
    input  fp_add_pkg::sig_t i_small_sig,
    input  logic             i_force_inf,
    input  logic             i_pass_zero,
    output logic             o_valid,
    output logic             o_sign,
    output fp_add_pkg::exp_t o_exp,
    output fp_add_pkg::sum_t o_sum,
    output logic             o_force_inf,
    output logic             o_is_zero
);
    logic             same_sign;
    fp_add_pkg::sum_t sum;

    assign same_sign = (i_big_sign == i_small_sign);

    // big >= small, so the difference never goes negative
    assign sum = same_sign ? ({1'b0, i_big_sig} + {1'b0, i_small_sig})
                           : ({1'b0, i_big_sig} - {1'b0, i_small_sig});

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sign      <= i_big_sign;               // larger operand decides
            o_exp       <= i_exp;
            o_sum       <= sum;
            o_force_inf <= i_force_inf;
            o_is_zero   <= i_pass_zero | (sum == '0); // both zero or exact cancel
        end
    end

endmodule

//--- hdl/fp_unpack_align.sv
module fp_unpack_align (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  fp_add_pkg::fp_word_t i_fp1,
    input  fp_add_pkg::fp_word_t i_fp2,
    output logic                 o_valid,
    output logic                 o_big_sign,
    output logic                 o_small_sign,
    output fp_add_pkg::exp_t     o_exp,
    output fp_add_pkg::sig_t     o_big_sig,
    output fp_add_pkg::sig_t     o_small_sig,
    output logic                 o_force_inf,
    output logic                 o_pass_zero
);
    logic                         fp1_sign;
    fp_add_pkg::exp_t             fp1_exp;
    logic [fp_add_pkg::MAN_W-1:0] fp1_man;
    fp_add_pkg::sig_t             fp1_sig;
    logic                         fp1_inf;
    logic                         fp1_zero;

    logic                         fp2_sign;
    fp_add_pkg::exp_t             fp2_exp;
    logic [fp_add_pkg::MAN_W-1:0] fp2_man;
    fp_add_pkg::sig_t             fp2_sig;
    logic                         fp2_inf;
    logic                         fp2_zero;

    logic                         fp1_big;
    fp_add_pkg::exp_t             big_exp;
    fp_add_pkg::exp_t             small_exp;
    fp_add_pkg::exp_t             exp_diff;
    fp_add_pkg::sig_t             big_sig;
    fp_add_pkg::sig_t             small_sig;
    fp_add_pkg::sig_t             small_aligned;

    assign fp1_sign = i_fp1[fp_add_pkg::FP_W-1];
    assign fp1_exp  = i_fp1[fp_add_pkg::FP_W-2 -: fp_add_pkg::EXP_W];
    assign fp1_man  = i_fp1[fp_add_pkg::MAN_W-1:0];
    assign fp2_sign = i_fp2[fp_add_pkg::FP_W-1];
    assign fp2_exp  = i_fp2[fp_add_pkg::FP_W-2 -: fp_add_pkg::EXP_W];
    assign fp2_man  = i_fp2[fp_add_pkg::MAN_W-1:0];

    assign fp1_inf  = (fp1_exp == fp_add_pkg::EXP_MAX);
    assign fp2_inf  = (fp2_exp == fp_add_pkg::EXP_MAX);
    assign fp1_zero = (fp1_exp == '0);                     // denormals flush to zero
    assign fp2_zero = (fp2_exp == '0);

    assign fp1_sig = fp1_zero ? '0 : {1'b1, fp1_man};
    assign fp2_sig = fp2_zero ? '0 : {1'b1, fp2_man};

    // exponent and significand compared as one magnitude
    assign fp1_big = ({fp1_exp, fp1_sig} >= {fp2_exp, fp2_sig});

    assign big_exp   = fp1_big ? fp1_exp : fp2_exp;
    assign small_exp = fp1_big ? fp2_exp : fp1_exp;
    assign big_sig   = fp1_big ? fp1_sig : fp2_sig;
    assign small_sig = fp1_big ? fp2_sig : fp1_sig;

    assign exp_diff      = big_exp - small_exp;
    assign small_aligned = (exp_diff >= fp_add_pkg::SIG_W) ? '0 : (small_sig >> exp_diff);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_big_sign   <= fp1_big ? fp1_sign : fp2_sign;
            o_small_sign <= fp1_big ? fp2_sign : fp1_sign;
            o_exp        <= big_exp;
            o_big_sig    <= big_sig;
            o_small_sig  <= small_aligned;
            o_force_inf  <= fp1_inf | fp2_inf;
            o_pass_zero  <= fp1_zero & fp2_zero;
        end
    end

endmodule

//--- hdl/fp_add_pkg.sv
package fp_add_pkg;

    // binary32 field widths
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int FP_W  = 1 + EXP_W + MAN_W;

    localparam int SIG_W = MAN_W + 1;          // mantissa plus hidden bit

    // whole word, sign at FP_W-1, exponent below it, mantissa at the bottom
    typedef logic [FP_W-1:0] fp_word_t;

    typedef logic [EXP_W-1:0] exp_t;

    typedef logic [SIG_W-1:0] sig_t;

    typedef logic [SIG_W:0] sum_t;             // extra msb holds the carry

    // leading zero count, 0 .. SIG_W
    typedef logic [$clog2(SIG_W + 1)-1:0] lz_t;

    localparam exp_t EXP_MAX = '1;             // infinity or nan

endpackage
